// File: pkt_chk_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build defaults for the packet checker array
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef PKT_CHK_SETTINGS_SVH
`define PKT_CHK_SETTINGS_SVH

// checker ports behind the router
`define PKT_CHK_NUM_PORTS 4

// stream bytes per beat
`define PKT_CHK_DATA_BYTES 4

// longest legal packet, in bytes
`define PKT_CHK_MTU_BYTES 64

// good/bad counter width, counters saturate
`define PKT_CHK_CNT_WIDTH 16

`endif

// File: axis_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream-side types: data beat, keep mask, port number
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pkt_chk_settings.svh"

package axis_pkg;

    // one beat of payload, byte 0 in the low lane
    typedef logic [`PKT_CHK_DATA_BYTES*8-1:0] axis_data_t;

    // one enable bit per byte lane
    typedef logic [`PKT_CHK_DATA_BYTES-1:0] axis_keep_t;

    // tdest width
    // kept at one bit for a single-port build
    typedef logic [(`PKT_CHK_NUM_PORTS > 1 ? $clog2(`PKT_CHK_NUM_PORTS) : 1)-1:0] port_idx_t;

endpackage

// File: pkt_chk_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// checker and register types, verdict codes, register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pkt_chk_settings.svh"

package pkt_chk_pkg;

    // saturating packet counter
    typedef logic [`PKT_CHK_CNT_WIDTH-1:0] pkt_cnt_t;

    // byte length, one bit above the MTU range
    // so an overlength packet still reads back as such
    typedef logic [$clog2(`PKT_CHK_MTU_BYTES):0] pkt_len_t;

    // packet verdict
    typedef enum logic [1:0] {
        VERDICT_GOOD     = 2'd0,
        VERDICT_BAD_DATA = 2'd1,
        VERDICT_BAD_LEN  = 2'd2,
        VERDICT_BAD_KEEP = 2'd3
    } verdict_e;

    // apb bus
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // register map
    localparam apb_addr_t REG_CTRL        = 8'h00;
    localparam apb_addr_t REG_PORT_BASE   = 8'h10;
    localparam apb_addr_t REG_PORT_STRIDE = 8'h10;
    // offsets inside one port's window
    localparam apb_addr_t REG_GOOD        = 8'h00;
    localparam apb_addr_t REG_BAD         = 8'h04;
    localparam apb_addr_t REG_LEN         = 8'h08;

    // ctrl fields
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_CLEAR_BIT  = 1;

endpackage

// File: axis_dest_router.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// input register stage, steers beats to a checker by tdest
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pkt_chk_settings.svh"
`default_nettype none
`timescale 1ns/1ps

module axis_dest_router
    import axis_pkg::*;
#(
    parameter int NUM_PORTS = `PKT_CHK_NUM_PORTS
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 enable,
    input  logic                 s_tvalid,
    input  axis_data_t           s_tdata,
    input  axis_keep_t           s_tkeep,
    input  logic                 s_tlast,
    input  port_idx_t            s_tdest,
    output logic                 s_tready,
    output logic [NUM_PORTS-1:0] beat_valid,
    output axis_data_t           beat_data,
    output axis_keep_t           beat_keep,
    output logic                 beat_last
);

    logic                 accept;
    logic [NUM_PORTS-1:0] dest_onehot;

    // checkers never stall, only the enable holds the source off
    assign s_tready = enable;
    assign accept   = s_tvalid & s_tready;

    // tdest decode
    // out-of-range dest matches no port and the beat is dropped
    always_comb begin
        dest_onehot = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            dest_onehot[p] = (s_tdest == p);
        end
    end

    // per-port valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_valid <= '0;
        end else begin
            beat_valid <= accept ? dest_onehot : '0;
        end
    end

    // shared beat fields, only loaded on a handshake
    always_ff @(posedge clk) begin
        if (accept) begin
            beat_data <= s_tdata;
            beat_keep <= s_tkeep;
            beat_last <= s_tlast;
        end
    end

endmodule

`default_nettype wire

// File: axis_pkt_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-port packet checker: length, keep shape, byte pattern
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pkt_chk_settings.svh"
`default_nettype none
`timescale 1ns/1ps

module axis_pkt_chk
    import axis_pkg::*;
    import pkt_chk_pkg::*;
#(
    parameter int MTU_BYTES = `PKT_CHK_MTU_BYTES
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       clear,
    input  logic       beat_valid,
    input  axis_data_t beat_data,
    input  axis_keep_t beat_keep,
    input  logic       beat_last,
    output logic       verdict_valid,
    output verdict_e   verdict,
    output pkt_len_t   length
);

    localparam int       DATA_BYTES = $bits(axis_keep_t);
    localparam int       KB_W       = $clog2(DATA_BYTES + 1);
    localparam int       SUM_W      = $bits(pkt_len_t) + 1;
    localparam pkt_len_t LEN_MAX    = '1;

    // packet-in-progress state
    logic            in_pkt;
    logic [7:0]      first_byte;
    logic [7:0]      byte_ofs;
    pkt_len_t        byte_cnt;
    logic            err_data;
    logic            err_keep;
    logic            err_len;

    // current beat
    logic [7:0]      base_byte;
    logic [KB_W-1:0] keep_bytes;
    logic [SUM_W-1:0] len_sum;
    pkt_len_t        len_next;
    logic            beat_err_data;
    logic            beat_err_keep;
    logic            beat_err_len;
    logic            any_data;
    logic            any_keep;
    logic            any_len;
    verdict_e        verdict_next;

    // expected value of lane 0 in this beat
    // on the first beat the packet seeds itself
    assign base_byte = (in_pkt ? first_byte : beat_data[7:0]) + byte_ofs;

    // pattern check and kept-byte count
    always_comb begin
        beat_err_data = 1'b0;
        keep_bytes    = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (beat_keep[i]) begin
                keep_bytes = keep_bytes + 1'b1;
                // byte k = first + k, wraps at 256
                if (beat_data[8*i +: 8] != base_byte + 8'(i)) begin
                    beat_err_data = 1'b1;
                end
            end
        end
    end

    // keep shape
    // middle beats full, last beat a non-empty run from lane 0
    always_comb begin
        if (beat_last) begin
            beat_err_keep = (beat_keep == '0) ||
                            ((beat_keep & (beat_keep + 1'b1)) != '0);
        end else begin
            beat_err_keep = (beat_keep != '1);
        end
    end

    // running length, held at LEN_MAX once past it
    assign len_sum      = SUM_W'(byte_cnt) + SUM_W'(keep_bytes);
    assign len_next     = (len_sum > SUM_W'(LEN_MAX)) ? LEN_MAX : pkt_len_t'(len_sum);
    assign beat_err_len = (len_next > pkt_len_t'(MTU_BYTES));

    // sticky flags merged with this beat
    assign any_data = err_data | beat_err_data;
    assign any_keep = err_keep | beat_err_keep;
    assign any_len  = err_len  | beat_err_len;

    // data first, then keep, then length
    always_comb begin
        if (any_data) begin
            verdict_next = VERDICT_BAD_DATA;
        end else if (any_keep) begin
            verdict_next = VERDICT_BAD_KEEP;
        end else if (any_len) begin
            verdict_next = VERDICT_BAD_LEN;
        end else begin
            verdict_next = VERDICT_GOOD;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_pkt        <= 1'b0;
            byte_ofs      <= '0;
            byte_cnt      <= '0;
            err_data      <= 1'b0;
            err_keep      <= 1'b0;
            err_len       <= 1'b0;
            verdict_valid <= 1'b0;
        end else if (clear) begin
            // drop whatever packet is half way through
            in_pkt        <= 1'b0;
            byte_ofs      <= '0;
            byte_cnt      <= '0;
            err_data      <= 1'b0;
            err_keep      <= 1'b0;
            err_len       <= 1'b0;
            verdict_valid <= 1'b0;
        end else begin
            verdict_valid <= beat_valid & beat_last;
            if (beat_valid) begin
                if (beat_last) begin
                    // re-arm for the next packet
                    in_pkt   <= 1'b0;
                    byte_ofs <= '0;
                    byte_cnt <= '0;
                    err_data <= 1'b0;
                    err_keep <= 1'b0;
                    err_len  <= 1'b0;
                end else begin
                    in_pkt   <= 1'b1;
                    byte_ofs <= byte_ofs + 8'(DATA_BYTES);
                    byte_cnt <= len_next;
                    err_data <= any_data;
                    err_keep <= any_keep;
                    err_len  <= any_len;
                end
            end
        end
    end

    // seed byte and verdict payload
    always_ff @(posedge clk) begin
        if (beat_valid && !in_pkt) begin
            first_byte <= beat_data[7:0];
        end
        if (beat_valid && beat_last) begin
            verdict <= verdict_next;
            length  <= len_next;
        end
    end

endmodule

`default_nettype wire

// File: pkt_chk_csr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb register block: ctrl, per-port good/bad counts, length
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pkt_chk_settings.svh"
`default_nettype none
`timescale 1ns/1ps

module pkt_chk_csr
    import axis_pkg::*;
    import pkt_chk_pkg::*;
#(
    parameter int NUM_PORTS = `PKT_CHK_NUM_PORTS
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  apb_addr_t            paddr,
    input  apb_data_t            pwdata,
    output apb_data_t            prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic [NUM_PORTS-1:0] verdict_valid,
    input  verdict_e             verdict [NUM_PORTS],
    input  pkt_len_t             length [NUM_PORTS],
    output logic                 enable,
    output logic                 clear
);

    logic                 access;
    apb_addr_t            rel_addr;
    apb_addr_t            port_num;
    apb_addr_t            reg_ofs;
    port_idx_t            port_sel;
    logic                 hit_ctrl;
    logic                 hit_port;
    logic                 hit_reg;

    // verdicts one cycle late
    logic [NUM_PORTS-1:0] vv_q;
    verdict_e             verdict_q [NUM_PORTS];
    pkt_len_t             length_q [NUM_PORTS];

    pkt_cnt_t             good_cnt [NUM_PORTS];
    pkt_cnt_t             bad_cnt [NUM_PORTS];
    pkt_len_t             last_len [NUM_PORTS];

    // zero wait states
    assign access = psel & penable;
    assign pready = access;

    // address decode
    assign rel_addr = paddr - REG_PORT_BASE;
    assign port_num = rel_addr / REG_PORT_STRIDE;
    assign reg_ofs  = rel_addr % REG_PORT_STRIDE;
    assign port_sel = port_idx_t'(port_num);
    assign hit_ctrl = (paddr == REG_CTRL);
    assign hit_port = (paddr >= REG_PORT_BASE) && (port_num < NUM_PORTS);
    assign hit_reg  = hit_port &&
                      (reg_ofs == REG_GOOD || reg_ofs == REG_BAD || reg_ofs == REG_LEN);

    // unmapped, or a write into a port window
    assign pslverr = access & (~(hit_ctrl | hit_reg) | (pwrite & hit_reg));

    // read mux
    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata[CTRL_ENABLE_BIT] = enable;
        end else if (hit_reg) begin
            case (reg_ofs)
                REG_GOOD: prdata = apb_data_t'(good_cnt[port_sel]);
                REG_BAD:  prdata = apb_data_t'(bad_cnt[port_sel]);
                REG_LEN:  prdata = apb_data_t'(last_len[port_sel]);
                default:  prdata = '0;
            endcase
        end
    end

    // ctrl write, clear self-clears next cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable <= 1'b0;
            clear  <= 1'b0;
        end else begin
            clear <= 1'b0;
            if (access && pwrite && hit_ctrl) begin
                enable <= pwdata[CTRL_ENABLE_BIT];
                clear  <= pwdata[CTRL_CLEAR_BIT];
            end
        end
    end

    // verdict capture stage
    // anything landing during clear is thrown away
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vv_q <= '0;
        end else begin
            vv_q <= clear ? '0 : verdict_valid;
        end
    end

    always_ff @(posedge clk) begin
        verdict_q <= verdict;
        length_q  <= length;
    end

    // counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                good_cnt[p] <= '0;
                bad_cnt[p]  <= '0;
                last_len[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (clear) begin
                    good_cnt[p] <= '0;
                    bad_cnt[p]  <= '0;
                    last_len[p] <= '0;
                end else if (vv_q[p]) begin
                    last_len[p] <= length_q[p];
                    // hold at all ones
                    if (verdict_q[p] == VERDICT_GOOD) begin
                        if (good_cnt[p] != '1) begin
                            good_cnt[p] <= good_cnt[p] + 1'b1;
                        end
                    end else if (bad_cnt[p] != '1) begin
                        bad_cnt[p] <= bad_cnt[p] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: axis_array_pkt_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top: router, one checker per port, apb register block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pkt_chk_settings.svh"
`default_nettype none
`timescale 1ns/1ps

module axis_array_pkt_chk
    import axis_pkg::*;
    import pkt_chk_pkg::*;
#(
    parameter int NUM_PORTS = `PKT_CHK_NUM_PORTS,
    parameter int MTU_BYTES = `PKT_CHK_MTU_BYTES
) (
    input  logic       clk,
    input  logic       arst_n,
    // stream in
    input  logic       s_tvalid,
    input  axis_data_t s_tdata,
    input  axis_keep_t s_tkeep,
    input  logic       s_tlast,
    input  port_idx_t  s_tdest,
    output logic       s_tready,
    // apb
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr
);

    // control from the register block
    logic                 enable;
    logic                 clear;

    // router to checkers
    logic [NUM_PORTS-1:0] beat_valid;
    axis_data_t           beat_data;
    axis_keep_t           beat_keep;
    logic                 beat_last;

    // checkers to register block
    logic [NUM_PORTS-1:0] verdict_valid;
    verdict_e             verdict [NUM_PORTS];
    pkt_len_t             length [NUM_PORTS];

    axis_dest_router #(
        .NUM_PORTS ( NUM_PORTS )
    ) axis_dest_router_i (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .enable     ( enable     ),
        .s_tvalid   ( s_tvalid   ),
        .s_tdata    ( s_tdata    ),
        .s_tkeep    ( s_tkeep    ),
        .s_tlast    ( s_tlast    ),
        .s_tdest    ( s_tdest    ),
        .s_tready   ( s_tready   ),
        .beat_valid ( beat_valid ),
        .beat_data  ( beat_data  ),
        .beat_keep  ( beat_keep  ),
        .beat_last  ( beat_last  )
    );

    // one checker per port, beat fields shared
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        axis_pkt_chk #(
            .MTU_BYTES ( MTU_BYTES )
        ) axis_pkt_chk_i (
            .clk           ( clk              ),
            .arst_n        ( arst_n           ),
            .clear         ( clear            ),
            .beat_valid    ( beat_valid[p]    ),
            .beat_data     ( beat_data        ),
            .beat_keep     ( beat_keep        ),
            .beat_last     ( beat_last        ),
            .verdict_valid ( verdict_valid[p] ),
            .verdict       ( verdict[p]       ),
            .length        ( length[p]        )
        );
    end

    pkt_chk_csr #(
        .NUM_PORTS ( NUM_PORTS )
    ) pkt_chk_csr_i (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .psel          ( psel          ),
        .penable       ( penable       ),
        .pwrite        ( pwrite        ),
        .paddr         ( paddr         ),
        .pwdata        ( pwdata        ),
        .prdata        ( prdata        ),
        .pready        ( pready        ),
        .pslverr       ( pslverr       ),
        .verdict_valid ( verdict_valid ),
        .verdict       ( verdict       ),
        .length        ( length        ),
        .enable        ( enable        ),
        .clear         ( clear         )
    );

endmodule

`default_nettype wire

// File: axis_array_pkt_chk_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound assertions: stream hold, apb ready, verdict pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pkt_chk_settings.svh"
`timescale 1ns/1ps

module axis_array_pkt_chk_sva
    import axis_pkg::*;
#(
    parameter int NUM_PORTS = `PKT_CHK_NUM_PORTS
) (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 s_tvalid,
    input logic                 s_tready,
    input axis_data_t           s_tdata,
    input logic                 psel,
    input logic                 penable,
    input logic                 pready,
    input logic [NUM_PORTS-1:0] beat_valid,
    input logic                 beat_last,
    input logic [NUM_PORTS-1:0] verdict_valid
);

    // stalled beat keeps its payload
    a_tdata_stable: assert property (@(posedge clk) disable iff (!arst_n)
        s_tvalid && !s_tready |=> $stable(s_tdata))
        else $error("s_tdata changed while the beat was stalled");

    // no wait states
    a_pready: assert property (@(posedge clk) disable iff (!arst_n)
        psel && penable |-> pready)
        else $error("pready low in an apb access phase");

    // at most one port reports per cycle
    a_verdict_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(verdict_valid))
        else $error("more than one verdict pulse in one cycle");

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // pulse follows a last beat on the same port
        a_verdict_after_last: assert property (@(posedge clk) disable iff (!arst_n)
            verdict_valid[p] |-> $past(beat_valid[p] && beat_last))
            else $error("verdict pulse on port %0d without a last beat", p);
    end

endmodule

bind axis_array_pkt_chk axis_array_pkt_chk_sva #(
    .NUM_PORTS ( NUM_PORTS )
) axis_array_pkt_chk_sva_i (
    .clk           ( clk           ),
    .arst_n        ( arst_n        ),
    .s_tvalid      ( s_tvalid      ),
    .s_tready      ( s_tready      ),
    .s_tdata       ( s_tdata       ),
    .psel          ( psel          ),
    .penable       ( penable       ),
    .pready        ( pready        ),
    .beat_valid    ( beat_valid    ),
    .beat_last     ( beat_last     ),
    .verdict_valid ( verdict_valid )
);

// File: tb_axis_array_pkt_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench: packet table, stream driver, apb reads, checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pkt_chk_settings.svh"
`timescale 1ns/1ps

module tb_axis_array_pkt_chk
    import axis_pkg::*;
    import pkt_chk_pkg::*;
();

    localparam int NUM_PORTS  = `PKT_CHK_NUM_PORTS;
    localparam int DATA_BYTES = `PKT_CHK_DATA_BYTES;
    localparam int MAX_ROWS   = 16;

    logic       clk;
    logic       arst_n;
    logic       s_tvalid;
    axis_data_t s_tdata;
    axis_keep_t s_tkeep;
    logic       s_tlast;
    port_idx_t  s_tdest;
    logic       s_tready;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;

    // stimulus table
    // seed -1 picks a random first byte
    // corrupt -1 means no corrupt byte
    string      t_name [MAX_ROWS];
    int         t_port [MAX_ROWS];
    int         t_len [MAX_ROWS];
    int         t_seed [MAX_ROWS];
    int         t_corrupt [MAX_ROWS];
    bit         t_bad_keep [MAX_ROWS];
    verdict_e   t_exp [MAX_ROWS];
    int         n_rows = 0;

    // model of the register block
    pkt_cnt_t   exp_good [NUM_PORTS];
    pkt_cnt_t   exp_bad [NUM_PORTS];
    pkt_len_t   exp_len [NUM_PORTS];

    integer     seed;
    int         err_cnt = 0;
    int         err_len = 0;
    int         err_apb = 0;
    int         err_other = 0;
    int         cycle_cnt = 0;
    int         cycle_limit = 0;

    axis_array_pkt_chk axis_array_pkt_chk_i (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .s_tvalid ( s_tvalid ),
        .s_tdata  ( s_tdata  ),
        .s_tkeep  ( s_tkeep  ),
        .s_tlast  ( s_tlast  ),
        .s_tdest  ( s_tdest  ),
        .s_tready ( s_tready ),
        .psel     ( psel     ),
        .penable  ( penable  ),
        .pwrite   ( pwrite   ),
        .paddr    ( paddr    ),
        .pwdata   ( pwdata   ),
        .prdata   ( prdata   ),
        .pready   ( pready   ),
        .pslverr  ( pslverr  )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic add_row(input string name, input int port, input int len, input int sd,
                           input int corrupt, input bit bad_keep, input verdict_e exp);
        t_name[n_rows]     = name;
        t_port[n_rows]     = port;
        t_len[n_rows]      = len;
        t_seed[n_rows]     = sd;
        t_corrupt[n_rows]  = corrupt;
        t_bad_keep[n_rows] = bad_keep;
        t_exp[n_rows]      = exp;
        n_rows++;
    endtask

    task automatic check_cnt(input string name, input pkt_cnt_t exp, input pkt_cnt_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_len(input string name, input pkt_len_t exp, input pkt_len_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            err_len++;
        end
    endtask

    task automatic check_apb_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected pslverr %0b, actual %0b", name, exp, act);
            err_apb++;
        end
    endtask

    // setup and access phases
    // response sampled at the falling edge of the access phase
    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              input logic exp_err, input string name, output apb_data_t rdata);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        if (pready !== 1'b1) begin
            $display("pready was not high in the access phase of %s", name);
            err_apb++;
        end
        check_apb_err(name, exp_err, pslverr);
        rdata = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // all three registers of every port against the model
    task automatic check_port_regs(input string tag);
        apb_data_t rd;
        apb_addr_t base;
        for (int p = 0; p < NUM_PORTS; p++) begin
            base = apb_addr_t'(REG_PORT_BASE + p * REG_PORT_STRIDE);
            apb_access(1'b0, base + REG_GOOD, '0, 1'b0, $sformatf("%s p%0d good", tag, p), rd);
            check_cnt($sformatf("%s p%0d good", tag, p), exp_good[p], pkt_cnt_t'(rd));
            apb_access(1'b0, base + REG_BAD, '0, 1'b0, $sformatf("%s p%0d bad", tag, p), rd);
            check_cnt($sformatf("%s p%0d bad", tag, p), exp_bad[p], pkt_cnt_t'(rd));
            apb_access(1'b0, base + REG_LEN, '0, 1'b0, $sformatf("%s p%0d len", tag, p), rd);
            check_len($sformatf("%s p%0d len", tag, p), exp_len[p], pkt_len_t'(rd));
        end
    endtask

    // one row as a packet
    // optional idle cycles between beats
    task automatic send_packet(input int r, input bit gaps);
        int         nbeats;
        int         seed_b;
        int         gap;
        int         k;
        logic [7:0] byte_v;
        axis_data_t data;
        axis_keep_t keep;
        logic       ready;
        nbeats = (t_len[r] + DATA_BYTES - 1) / DATA_BYTES;
        seed_b = (t_seed[r] < 0) ? ($random(seed) & 'hff) : t_seed[r];
        for (int b = 0; b < nbeats; b++) begin
            // lane i carries byte b*DATA_BYTES+i of the run
            for (int i = 0; i < DATA_BYTES; i++) begin
                k      = b * DATA_BYTES + i;
                byte_v = 8'(seed_b + k);
                if (k == t_corrupt[r]) begin
                    byte_v = byte_v ^ 8'h01;
                end
                data[8*i +: 8] = byte_v;
            end
            // full middle beats, low run on the last, or a split mask
            if (b < nbeats - 1) begin
                keep = '1;
            end else if (t_bad_keep[r]) begin
                keep = axis_keep_t'(5);
            end else begin
                keep = axis_keep_t'((1 << (t_len[r] - b * DATA_BYTES)) - 1);
            end
            gap = gaps ? $unsigned($random(seed)) % 3 : 0;
            if (gap > 0) begin
                s_tvalid = 1'b0;
                repeat (gap) @(posedge clk);
                #1;
            end
            s_tvalid = 1'b1;
            s_tdata  = data;
            s_tkeep  = keep;
            s_tlast  = (b == nbeats - 1);
            s_tdest  = port_idx_t'(t_port[r]);
            // hold until the router takes it
            ready = 1'b0;
            while (!ready) begin
                @(negedge clk);
                ready = s_tready;
                @(posedge clk);
            end
            #1;
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        // verdict class picks the counter
        if (t_exp[r] == VERDICT_GOOD) begin
            exp_good[t_port[r]] = exp_good[t_port[r]] + 1'b1;
        end else begin
            exp_bad[t_port[r]] = exp_bad[t_port[r]] + 1'b1;
        end
        // length register holds the row's byte count
        exp_len[t_port[r]] = pkt_len_t'(t_len[r]);
    endtask

    initial begin
        apb_data_t rd;
        int        total_beats;
        arst_n   = 1'b0;
        s_tvalid = 1'b0;
        s_tdata  = '0;
        s_tkeep  = '0;
        s_tlast  = 1'b0;
        s_tdest  = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        seed     = 32'hd66c;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_good[p] = '0;
            exp_bad[p]  = '0;
            exp_len[p]  = '0;
        end

        // name, port, length, seed, corrupt index, bad keep, verdict
        add_row("len1_p0", 0, 1, 'h10, -1, 1'b0, VERDICT_GOOD);
        add_row("len4_p1", 1, 4, -1, -1, 1'b0, VERDICT_GOOD);
        add_row("wrap_len7_p2", 2, 7, 'hfe, -1, 1'b0, VERDICT_GOOD);
        add_row("mtu_p3", 3, `PKT_CHK_MTU_BYTES, -1, -1, 1'b0, VERDICT_GOOD);
        add_row("len13_p0", 0, 13, 'hf8, -1, 1'b0, VERDICT_GOOD);
        add_row("corrupt_p1", 1, 20, 'h33, 9, 1'b0, VERDICT_BAD_DATA);
        add_row("overlen_p2", 2, `PKT_CHK_MTU_BYTES + 1, -1, -1, 1'b0, VERDICT_BAD_LEN);
        add_row("split_keep_p3", 3, 10, 'h44, -1, 1'b1, VERDICT_BAD_KEEP);
        add_row("len2_p3", 3, 2, -1, -1, 1'b0, VERDICT_GOOD);

        // two passes of beats plus every apb access
        // with a margin of four
        total_beats = 0;
        for (int r = 0; r < n_rows; r++) begin
            total_beats += 2 * ((t_len[r] + DATA_BYTES - 1) / DATA_BYTES);
        end
        cycle_limit = (total_beats + 4 * (3 * NUM_PORTS * (n_rows + 4) + 8)) * 4;

        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        if (s_tready !== 1'b0) begin
            $display("s_tready is high after reset while the array is disabled");
            err_other++;
        end
        check_port_regs("reset");

        // first row offered while still disabled
        // the beat stalls until the enable write lands
        fork
            send_packet(0, 1'b0);
            apb_access(1'b1, REG_CTRL, 32'h1, 1'b0, "enable write", rd);
        join
        if (s_tready !== 1'b1) begin
            $display("s_tready stayed low after the enable write");
            err_other++;
        end

        // one packet at a time
        // counters settle 3 cycles after the last beat
        for (int r = 0; r < n_rows; r++) begin
            send_packet(r, 1'b0);
            repeat (4) @(posedge clk);
            #1;
            check_port_regs(t_name[r]);
        end

        // whole table back to back with idle gaps
        for (int r = 0; r < n_rows; r++) begin
            send_packet(r, 1'b1);
        end
        repeat (4) @(posedge clk);
        #1;
        check_port_regs("burst");

        // clear keeps enable set
        apb_access(1'b1, REG_CTRL, 32'h3, 1'b0, "clear write", rd);
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_good[p] = '0;
            exp_bad[p]  = '0;
            exp_len[p]  = '0;
        end
        check_port_regs("clear");

        // slave errors
        apb_access(1'b0, 8'h04, '0, 1'b1, "unmapped read", rd);
        apb_access(1'b0, apb_addr_t'(REG_PORT_BASE + NUM_PORTS * REG_PORT_STRIDE), '0, 1'b1,
                   "read past last port", rd);
        apb_access(1'b0, REG_PORT_BASE + 8'h0c, '0, 1'b1, "hole in port window", rd);
        apb_access(1'b1, REG_PORT_BASE + REG_GOOD, 32'h5, 1'b1, "counter write", rd);
        check_port_regs("after errors");

        $display("errors: count %0d, length %0d, apb %0d, other %0d",
                 err_cnt, err_len, err_apb, err_other);
        if (err_cnt + err_len + err_apb + err_other == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+.
axis_pkg.sv
pkt_chk_pkg.sv
axis_dest_router.sv
axis_pkt_chk.sv
pkt_chk_csr.sv
axis_array_pkt_chk.sv
axis_array_pkt_chk_sva.sv
tb_axis_array_pkt_chk.sv

// File: Bender.yml
package:
  name: axis_array_pkt_chk

sources:
  - include_dirs:
      - .
    files:
      - axis_pkg.sv
      - pkt_chk_pkg.sv
      - axis_dest_router.sv
      - axis_pkt_chk.sv
      - pkt_chk_csr.sv
      - axis_array_pkt_chk.sv
  - target: test
    include_dirs:
      - .
    files:
      - axis_array_pkt_chk_sva.sv
      - tb_axis_array_pkt_chk.sv
